// File: hw/approxMul_defs.svh
`ifndef APPROX_MUL_DEFS_SVH
`define APPROX_MUL_DEFS_SVH

// Operand width of one full multiply request.
`define APPROX_OP_W 16

// Operand width of the pipelined core.
`define APPROX_BYTE_W 8

// One accuracy bit per error-configurable adder column.
`define APPROX_ER_W 7

// Register stages between core input and core output.
`define APPROX_CORE_LAT 2

`endif

// File: hw/approxMulPkg.sv
`default_nettype none

`include "approxMul_defs.svh"

package approxMulPkg;

    typedef logic [`APPROX_BYTE_W-1:0] opByte;
    typedef logic [`APPROX_ER_W-1:0] erCtrl;
    typedef logic [2*`APPROX_BYTE_W-1:0] byteProd;
    typedef logic [2*`APPROX_OP_W-1:0] wordProd;

    // Second-level compressor outputs span the byte plus three extra columns.
    typedef logic [`APPROX_BYTE_W+2:0] rowP;
    typedef logic [2*`APPROX_BYTE_W-2:0] rowV;

    typedef logic [2*`APPROX_BYTE_W-2:0] sumCarry;

    // Returns {carry, sum}.
    function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic c);
        logic s;
        logic co;
        s = a ^ b ^ c;
        co = (a & b) | (a & c) | (b & c);
        return {co, s};
    endfunction

endpackage

`default_nettype wire

// File: hw/ppCompressStage.sv
`default_nettype none

`include "approxMul_defs.svh"

module ppCompressStage
    import approxMulPkg::*;
(
    input  opByte opA,
    input  opByte opB,
    output rowP   p5,
    output rowP   p6,
    output rowV   v1,
    output rowV   v2
);

    localparam int NumRows = `APPROX_BYTE_W;
    localparam int NumPairs1 = NumRows / 2;
    localparam int NumPairs2 = NumPairs1 / 2;

    opByte pp [NumRows];

    logic [`APPROX_BYTE_W:0] p1 [NumPairs1];
    logic [`APPROX_BYTE_W:0] q1 [NumPairs1];

    rowP p2 [NumPairs2];
    rowP q2 [NumPairs2];

    for (genvar i = 0; i < NumRows; i++) begin : gRow
        assign pp[i] = opA & {`APPROX_BYTE_W{opB[i]}};
    end

    // First level pairs adjacent rows, the upper row one column to the left.
    // Overlapping columns keep only the OR, and the AND goes to v1.
    for (genvar j = 0; j < NumPairs1; j++) begin : gLevel1
        assign p1[j] = {1'b0, pp[2*j]} | {pp[2*j+1], 1'b0};
        assign q1[j] = {1'b0, pp[2*j]} & {pp[2*j+1], 1'b0};
    end

    // Second level pairs the first-level words, two columns apart.
    for (genvar k = 0; k < NumPairs2; k++) begin : gLevel2
        assign p2[k] = {2'b00, p1[2*k]} | {p1[2*k+1], 2'b00};
        assign q2[k] = {2'b00, p1[2*k]} & {p1[2*k+1], 2'b00};
    end

    // Pair j of the first level sits at column 2*j.
    always_comb begin
        v1 = '0;
        for (int j = 0; j < NumPairs1; j++) begin
            v1 = v1 | (rowV'(q1[j]) << (2 * j));
        end
    end

    assign v2 = rowV'(q2[0]) | (rowV'(q2[1]) << 4);

    assign p5 = p2[0];
    assign p6 = p2[1];

endmodule

`default_nettype wire

// File: hw/approxReduceStage.sv
`default_nettype none

module approxReduceStage
    import approxMulPkg::*;
(
    input  rowP     p5,
    input  rowP     p6,
    input  rowV     v1,
    input  rowV     v2,
    output sumCarry sumRow,
    output sumCarry carryRow
);

    // Columns where v1 and v2 are merged by OR before the adder.
    localparam int OrLo = 4;
    localparam int OrHi = 10;

    localparam int TopCol = $bits(sumCarry) - 1;

    rowV p7;
    rowV q7;

    // The last compressor places p6 four columns above p5.
    assign p7 = {4'b0000, p5} | {p6, 4'b0000};
    assign q7 = {4'b0000, p5} & {p6, 4'b0000};

    always_comb begin
        logic inB;
        logic inC;
        logic [1:0] fa;

        sumRow = '0;
        carryRow = '0;

        sumRow[0] = p7[0];

        // Only p7 and v1 can be set in column 1.
        sumRow[1] = p7[1] ^ v1[1];
        carryRow[2] = p7[1] & v1[1];

        for (int c = 2; c < TopCol - 1; c++) begin
            if (c >= OrLo && c <= OrHi) begin
                inB = q7[c];
                inC = v1[c] | v2[c];
            end else begin
                inB = v1[c];
                inC = v2[c];
            end
            fa = fullAdd(p7[c], inB, inC);
            sumRow[c] = fa[0];
            carryRow[c + 1] = fa[1];
        end

        sumRow[TopCol - 1] = p7[TopCol - 1] ^ v1[TopCol - 1];
        carryRow[TopCol] = p7[TopCol - 1] & v1[TopCol - 1];

        sumRow[TopCol] = p7[TopCol];
    end

endmodule

`default_nettype wire

// File: hw/errorConfigAddStage.sv
`default_nettype none

`include "approxMul_defs.svh"

module errorConfigAddStage
    import approxMulPkg::*;
(
    input  erCtrl   er,
    input  sumCarry sumRow,
    input  sumCarry carryRow,
    output byteProd prod
);

    localparam int EcLo = 5;
    localparam int EcHi = EcLo + `APPROX_ER_W - 1;
    localparam int TopCol = $bits(sumCarry) - 1;

    always_comb begin
        logic carry;
        logic axb;
        logic [1:0] fa;

        prod = '0;
        prod[1:0] = sumRow[1:0];
        prod[EcLo-1:2] = sumRow[EcLo-1:2] | carryRow[EcLo-1:2];

        // The OR-only columns never produce a carry.
        carry = 1'b0;

        for (int c = EcLo; c <= EcHi; c++) begin
            axb = sumRow[c] ^ carryRow[c];
            if (er[c - EcLo]) begin
                fa = fullAdd(sumRow[c], carryRow[c], carry);
            end else begin
                fa = {sumRow[c] & (carryRow[c] | carry), axb | carry};
            end
            prod[c] = fa[0];
            carry = fa[1];
        end

        for (int c = EcHi + 1; c <= TopCol; c++) begin
            fa = fullAdd(sumRow[c], carryRow[c], carry);
            prod[c] = fa[0];
            carry = fa[1];
        end

        prod[TopCol + 1] = carry;
    end

endmodule

`default_nettype wire

// File: hw/approxMulCore8.sv
`default_nettype none

`include "approxMul_defs.svh"

module approxMulCore8
    import approxMulPkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    input  opByte   opA,
    input  opByte   opB,
    input  erCtrl   er,
    input  logic    inValid,
    output byteProd prod,
    output logic    prodValid
);

    rowP p5;
    rowP p6;
    rowV v1;
    rowV v2;

    rowP   p5Q;
    rowP   p6Q;
    rowV   v1Q;
    rowV   v2Q;
    erCtrl er1Q;

    sumCarry sumRow;
    sumCarry carryRow;
    sumCarry sumQ;
    sumCarry carryQ;
    erCtrl   er2Q;

    logic [`APPROX_CORE_LAT-1:0] validPipe;

    ppCompressStage i_ppCompressStage (
        .opA(opA),
        .opB(opB),
        .p5 (p5),
        .p6 (p6),
        .v1 (v1),
        .v2 (v2)
    );

    approxReduceStage i_approxReduceStage (
        .p5      (p5Q),
        .p6      (p6Q),
        .v1      (v1Q),
        .v2      (v2Q),
        .sumRow  (sumRow),
        .carryRow(carryRow)
    );

    errorConfigAddStage i_errorConfigAddStage (
        .er      (er2Q),
        .sumRow  (sumQ),
        .carryRow(carryQ),
        .prod    (prod)
    );

    // The accuracy word travels with its data through both stage registers.
    always_ff @(posedge CLK) begin
        p5Q <= p5;
        p6Q <= p6;
        v1Q <= v1;
        v2Q <= v2;
        er1Q <= er;
        sumQ <= sumRow;
        carryQ <= carryRow;
        er2Q <= er1Q;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[`APPROX_CORE_LAT-2:0], inValid};
        end
    end

    assign prodValid = validPipe[`APPROX_CORE_LAT-1];

endmodule

`default_nettype wire

// File: hw/approxMulSeq16.sv
`default_nettype none

`include "approxMul_defs.svh"

module approxMulSeq16
    import approxMulPkg::*;
(
    input  logic                   CLK,
    input  logic                   rst,
    input  logic [`APPROX_OP_W-1:0] opA,
    input  logic [`APPROX_OP_W-1:0] opB,
    input  erCtrl                  er,
    input  logic                   inValid,
    output logic                   inReady,
    output wordProd                result,
    output logic                   outValid,
    input  logic                   outReady,
    output opByte                  coreA,
    output opByte                  coreB,
    output erCtrl                  coreEr,
    output logic                   coreValid,
    input  byteProd                coreProd,
    input  logic                   coreProdValid
);

    typedef enum logic [1:0] {
        sIdle,
        sIssue,
        sDrain,
        sHold
    } seqState;

    seqState state;

    logic [1:0] issueCnt;
    logic [1:0] retCnt;

    logic [`APPROX_OP_W-1:0] opAQ;
    logic [`APPROX_OP_W-1:0] opBQ;
    erCtrl                   erQ;
    wordProd                 acc;
    wordProd                 addend;
    logic                    accept;

    // A held result may be replaced in the same cycle that it is taken.
    assign inReady = (state == sIdle) || ((state == sHold) && outReady);
    assign accept = inValid && inReady;

    assign outValid = (state == sHold);
    assign result = acc;
    assign coreEr = erQ;

    // Products come back as LL, HL, LH, HH.
    always_comb begin
        case (retCnt)
            2'd0: addend = wordProd'(coreProd);
            2'd1, 2'd2: addend = wordProd'(coreProd) << `APPROX_BYTE_W;
            default: addend = wordProd'(coreProd) << (2 * `APPROX_BYTE_W);
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= sIdle;
            issueCnt <= '0;
            retCnt <= '0;
            coreValid <= 1'b0;
        end else begin
            coreValid <= (state == sIssue);
            if (coreProdValid) begin
                retCnt <= retCnt + 2'd1;
            end
            case (state)
                sIdle: begin
                    if (accept) begin
                        state <= sIssue;
                    end
                end
                sIssue: begin
                    issueCnt <= issueCnt + 2'd1;
                    if (issueCnt == 2'd3) begin
                        state <= sDrain;
                    end
                end
                sDrain: begin
                    if (coreProdValid && (retCnt == 2'd3)) begin
                        state <= sHold;
                    end
                end
                default: begin
                    if (accept) begin
                        state <= sIssue;
                    end else if (outReady) begin
                        state <= sIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            opAQ <= opA;
            opBQ <= opB;
            erQ <= er;
            acc <= '0;
        end else if (coreProdValid) begin
            acc <= acc + addend;
        end
        // Bit 0 of the count picks the high byte of A, bit 1 that of B.
        if (state == sIssue) begin
            coreA <= issueCnt[0] ? opAQ[`APPROX_OP_W-1:`APPROX_BYTE_W]
                                 : opAQ[`APPROX_BYTE_W-1:0];
            coreB <= issueCnt[1] ? opBQ[`APPROX_OP_W-1:`APPROX_BYTE_W]
                                 : opBQ[`APPROX_BYTE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/approxMulTop.sv
`default_nettype none

`include "approxMul_defs.svh"

module approxMulTop
    import approxMulPkg::*;
(
    input  logic                    CLK,
    input  logic                    rst,
    input  logic [`APPROX_OP_W-1:0] opA,
    input  logic [`APPROX_OP_W-1:0] opB,
    input  erCtrl                   er,
    input  logic                    inValid,
    output logic                    inReady,
    output wordProd                 result,
    output logic                    outValid,
    input  logic                    outReady
);

    opByte   coreA;
    opByte   coreB;
    erCtrl   coreEr;
    logic    coreValid;
    byteProd coreProd;
    logic    coreProdValid;

    approxMulSeq16 i_approxMulSeq16 (
        .CLK          (CLK),
        .rst          (rst),
        .opA          (opA),
        .opB          (opB),
        .er           (er),
        .inValid      (inValid),
        .inReady      (inReady),
        .result       (result),
        .outValid     (outValid),
        .outReady     (outReady),
        .coreA        (coreA),
        .coreB        (coreB),
        .coreEr       (coreEr),
        .coreValid    (coreValid),
        .coreProd     (coreProd),
        .coreProdValid(coreProdValid)
    );

    approxMulCore8 i_approxMulCore8 (
        .CLK      (CLK),
        .rst      (rst),
        .opA      (coreA),
        .opB      (coreB),
        .er       (coreEr),
        .inValid  (coreValid),
        .prod     (coreProd),
        .prodValid(coreProdValid)
    );

endmodule

`default_nettype wire

// File: testbench/approxMulRefModel.sv
`default_nettype none

`include "approxMul_defs.svh"

package approxMulRefModel;

    localparam int ByteW = `APPROX_BYTE_W;
    localparam int ColW = 2 * `APPROX_BYTE_W - 1;
    localparam int WordW = 2 * `APPROX_OP_W;
    localparam int EcLo = 5;
    localparam int EcHi = EcLo + `APPROX_ER_W - 1;

    // Every intermediate word sits at its absolute column position.
    function automatic logic [2*ByteW-1:0] byteMulModel(
        input logic [ByteW-1:0]        a,
        input logic [ByteW-1:0]        b,
        input logic [`APPROX_ER_W-1:0] er
    );
        logic [ColW-1:0] row [ByteW];
        logic [ColW-1:0] p1 [ByteW/2];
        logic [ColW-1:0] p2 [2];
        logic [ColW-1:0] v1;
        logic [ColW-1:0] v2;
        logic [ColW-1:0] p7;
        logic [ColW-1:0] q7;
        logic [ColW-1:0] s;
        logic [ColW:0] cy;
        logic [2*ByteW-1:0] p;
        logic x;
        logic y;
        logic z;
        logic cin;
        logic nxt;

        v1 = '0;
        v2 = '0;
        for (int i = 0; i < ByteW; i++) begin
            row[i] = ColW'(a & {ByteW{b[i]}}) << i;
        end
        // Each compressor keeps the OR of a pair and sends the AND to the V vectors.
        for (int j = 0; j < ByteW / 2; j++) begin
            p1[j] = row[2*j] | row[2*j+1];
            v1 = v1 | (row[2*j] & row[2*j+1]);
        end
        for (int k = 0; k < 2; k++) begin
            p2[k] = p1[2*k] | p1[2*k+1];
            v2 = v2 | (p1[2*k] & p1[2*k+1]);
        end
        p7 = p2[0] | p2[1];
        q7 = p2[0] & p2[1];

        cy = '0;
        for (int c = 0; c < ColW; c++) begin
            x = p7[c];
            if (c >= 4 && c <= 10) begin
                y = q7[c];
                z = v1[c] | v2[c];
            end else begin
                y = v1[c];
                z = v2[c];
            end
            s[c] = x ^ y ^ z;
            cy[c+1] = (x & y) | (x & z) | (y & z);
        end

        p = '0;
        cin = 1'b0;
        for (int c = 0; c < ColW; c++) begin
            x = s[c];
            y = cy[c];
            if (c < 2) begin
                p[c] = x;
            end else if (c < EcLo) begin
                p[c] = x | y;
            end else if (c <= EcHi && !er[c-EcLo]) begin
                p[c] = (x ^ y) | cin;
                cin = x & (y | cin);
            end else begin
                nxt = (x & y) | (x & cin) | (y & cin);
                p[c] = x ^ y ^ cin;
                cin = nxt;
            end
        end
        p[ColW] = cin;
        return p;
    endfunction

    // The four byte products weighted by their byte positions.
    function automatic logic [WordW-1:0] wordMulModel(
        input logic [`APPROX_OP_W-1:0] a,
        input logic [`APPROX_OP_W-1:0] b,
        input logic [`APPROX_ER_W-1:0] er
    );
        logic [WordW-1:0] ll;
        logic [WordW-1:0] hl;
        logic [WordW-1:0] lh;
        logic [WordW-1:0] hh;

        ll = WordW'(byteMulModel(a[ByteW-1:0], b[ByteW-1:0], er));
        hl = WordW'(byteMulModel(a[2*ByteW-1:ByteW], b[ByteW-1:0], er));
        lh = WordW'(byteMulModel(a[ByteW-1:0], b[2*ByteW-1:ByteW], er));
        hh = WordW'(byteMulModel(a[2*ByteW-1:ByteW], b[2*ByteW-1:ByteW], er));
        return ll + (hl << ByteW) + (lh << ByteW) + (hh << (2 * ByteW));
    endfunction

endpackage

`default_nettype wire

// File: testbench/tbApproxMul.sv
`default_nettype none

`include "approxMul_defs.svh"

module tbApproxMul
    import approxMulRefModel::*;
();

    localparam int OpW = `APPROX_OP_W;
    localparam int ErW = `APPROX_ER_W;
    localparam int ResW = 2 * `APPROX_OP_W;
    localparam int Latency = 7;
    localparam int WaitLimit = 20;

    logic CLK;
    logic rst;
    logic [OpW-1:0] opA;
    logic [OpW-1:0] opB;
    logic [ErW-1:0] er;
    logic inValid;
    logic inReady;
    logic [ResW-1:0] result;
    logic outValid;
    logic outReady;

    // Stimulus table with operands, accuracy word, outReady stall and expected result.
    logic [OpW-1:0] tblA [$];
    logic [OpW-1:0] tblB [$];
    logic [ErW-1:0] tblEr [$];
    int tblStall [$];
    logic [ResW-1:0] tblExp [$];

    int numErrors;
    int numChecks;
    int limitCycles;
    logic tableBuilt;

    approxMulTop i_approxMulTop (
        .CLK     (CLK),
        .rst     (rst),
        .opA     (opA),
        .opB     (opB),
        .er      (er),
        .inValid (inValid),
        .inReady (inReady),
        .result  (result),
        .outValid(outValid),
        .outReady(outReady)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic addRow(
        input logic [OpW-1:0]  a,
        input logic [OpW-1:0]  b,
        input logic [ErW-1:0]  e,
        input int              stall,
        input logic            useModel,
        input logic [ResW-1:0] fixedExp
    );
        tblA.push_back(a);
        tblB.push_back(b);
        tblEr.push_back(e);
        tblStall.push_back(stall);
        tblExp.push_back(useModel ? wordMulModel(a, b, e) : fixedExp);
    endtask

    task automatic buildTable();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [OpW-1:0] sweepA;
        logic [OpW-1:0] sweepB;

        addRow(16'h0000, 16'hFFFF, 7'h00, 0, 1'b0, 32'h0);
        addRow(16'hBEEF, 16'h0000, 7'h7F, 1, 1'b0, 32'h0);
        addRow(16'h0000, 16'h1234, 7'h2A, 0, 1'b0, 32'h0);
        // A single set bit in one operand leaves no overlapping partial products
        addRow(16'h0001, 16'hBEEF, 7'h7F, 0, 1'b0, 32'h0000BEEF);
        addRow(16'h8000, 16'hFFFF, 7'h7F, 2, 1'b0, 32'h7FFF8000);
        addRow(16'hA5C3, 16'h0200, 7'h7F, 0, 1'b0, 32'h014B8600);
        addRow(16'h0040, 16'h1234, 7'h7F, 3, 1'b0, 32'h00048D00);
        addRow(16'hFFFF, 16'hFFFF, 7'h7F, 0, 1'b1, '0);
        addRow(16'h1234, 16'h5678, 7'h7F, 1, 1'b1, '0);
        addRow(16'hA5A5, 16'h5A5A, 7'h7F, 0, 1'b1, '0);

        // One operand pair swept over three accuracy words.
        rnd = $urandom();
        sweepA = rnd[15:0];
        sweepB = rnd[31:16];
        rnd2 = $urandom();
        addRow(sweepA, sweepB, 7'h00, 0, 1'b1, '0);
        addRow(sweepA, sweepB, 7'h7F, 0, 1'b1, '0);
        addRow(sweepA, sweepB, rnd2[6:0], 4, 1'b1, '0);

        for (int i = 0; i < 8; i++) begin
            rnd = $urandom();
            rnd2 = $urandom();
            addRow(rnd[15:0], rnd[31:16], rnd2[6:0], rnd2[15:8] % 5, 1'b1, '0);
        end
    endtask

    task automatic reportMismatch(
        input string           sigName,
        input logic [ResW-1:0] got,
        input logic [ResW-1:0] expected
    );
        numErrors++;
        $display("CHECK FAILED at time %0t: %s got %0h expected %0h",
                 $time, sigName, got, expected);
    endtask

    task automatic driveOp(input int idx);
        opA <= tblA[idx];
        opB <= tblB[idx];
        er <= tblEr[idx];
        inValid <= 1'b1;
    endtask

    initial begin : mainSeq
        int waited;
        int lat;
        int maxStall;
        logic [ResW-1:0] held;
        logic aborted;

        rst = 1'b1;
        opA = '0;
        opB = '0;
        er = '0;
        inValid = 1'b0;
        outReady = 1'b0;
        numErrors = 0;
        numChecks = 0;
        aborted = 1'b0;
        tableBuilt = 1'b0;
        void'($urandom(14));
        buildTable();
        maxStall = 0;
        foreach (tblStall[i]) begin
            if (tblStall[i] > maxStall) maxStall = tblStall[i];
        end
        // Each row costs its latency, the accept and take cycles and its stall.
        limitCycles = tblA.size() * (Latency + 2 + maxStall) + 5 + 50;
        tableBuilt = 1'b1;

        repeat (5) @(posedge CLK);
        rst <= 1'b0;
        @(posedge CLK);
        numChecks += 2;
        if (inReady !== 1'b1) reportMismatch("inReady", inReady, 1);
        if (outValid !== 1'b0) reportMismatch("outValid", outValid, 0);

        driveOp(0);
        for (int i = 0; i < tblA.size() && !aborted; i++) begin
            waited = 0;
            do begin
                @(posedge CLK);
                waited++;
            end while (!(inValid && inReady) && waited < WaitLimit);

            if (!(inValid && inReady)) begin
                $display("Row %0d was never accepted by the DUT", i);
                numErrors++;
                aborted = 1'b1;
            end else begin
                inValid <= 1'b0;
                outReady <= (tblStall[i] == 0);
                lat = 0;
                do begin
                    @(posedge CLK);
                    lat++;
                    if (!outValid) begin
                        numChecks++;
                        if (inReady !== 1'b0) reportMismatch("inReady", inReady, 0);
                    end
                end while (!outValid && lat < WaitLimit);

                if (!outValid) begin
                    $display("Row %0d produced no result", i);
                    numErrors++;
                    aborted = 1'b1;
                end else begin
                    // outValid is seen one edge after the edge that raised it.
                    numChecks += 2;
                    if (lat - 1 != Latency) reportMismatch("latency", lat - 1, Latency);
                    if (result !== tblExp[i]) reportMismatch("result", result, tblExp[i]);
                    held = result;
                    // The next operation waits at the input while this result is held.
                    if (i + 1 < tblA.size()) driveOp(i + 1);
                    repeat (tblStall[i]) begin
                        @(posedge CLK);
                        numChecks += 3;
                        if (outValid !== 1'b1) reportMismatch("outValid", outValid, 1);
                        if (result !== held) reportMismatch("result", result, held);
                        if (inReady !== 1'b0) reportMismatch("inReady", inReady, 0);
                    end
                    outReady <= 1'b1;
                end
            end
        end

        repeat (2) @(posedge CLK);
        numChecks += 2;
        if (outValid !== 1'b0) reportMismatch("outValid", outValid, 0);
        if (inReady !== 1'b1) reportMismatch("inReady", inReady, 1);

        $display("Summary: %0d rows, %0d checks, %0d errors",
                 tblA.size(), numChecks, numErrors);
        if (numErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (tableBuilt === 1'b1);
        repeat (limitCycles) @(posedge CLK);
        $display("Watchdog expired after %0d cycles before the table finished", limitCycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/approxMulPkg.sv
hw/ppCompressStage.sv
hw/approxReduceStage.sv
hw/errorConfigAddStage.sv
hw/approxMulCore8.sv
hw/approxMulSeq16.sv
hw/approxMulTop.sv
testbench/approxMulRefModel.sv
testbench/tbApproxMul.sv

// File: Bender.yml
package:
  name: approx_mul

export_include_dirs:
  - hw

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/approxMulPkg.sv
      - hw/ppCompressStage.sv
      - hw/approxReduceStage.sv
      - hw/errorConfigAddStage.sv
      - hw/approxMulCore8.sv
      - hw/approxMulSeq16.sv
      - hw/approxMulTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/approxMulRefModel.sv
      - testbench/tbApproxMul.sv
